// File: compile.f
+incdir+design
design/cipher_pkg.sv
design/cipher_key_schedule.sv
design/cipher_round_unit.sv
design/cipher_engine.sv
design/cipher_host.sv
sim/cipher_host_properties.sv
sim/cipher_host_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the cipher host testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cipher_host_tb \
    -f compile.f -o cipher_host_sim > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/cipher_host_sim > sim.log 2>&1 \
    || { cat sim.log; echo "Simulation stopped with an error"; exit 1; }

cat sim.log
grep -q "Regression failed" sim.log && exit 1
grep -q "Regression passed" sim.log || exit 1
exit 0

// File: sim/cipher_host_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cipher host testbench
// Directed tests against a cipher model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "cipher_defines.svh"

module cipher_host_tb;

    import cipher_pkg::*;

    typedef logic [`CIPHER_BLOCK_W-1:0] block_t;

    localparam int NBYTES       = `CIPHER_BLOCK_W / 8;
    localparam int LATENCY      = `CIPHER_ROUNDS + 1;
    localparam int DONE_TIMEOUT = 4 * LATENCY;

    logic        clk = 1'b0;
    logic        rst;
    cipher_req_t req;
    cipher_rsp_t rsp;
    logic        busy;

    integer seed       = 2;
    int     err_count  = 0;
    int     test_count = 0;
    int     fail_count = 0;
    int     done_count = 0;

    always #2 clk = ~clk;  // 4 ns period

    // Every done pulse seen by the DUT's consumer
    always @(posedge clk) begin
        if (rsp.done) begin
            done_count <= done_count + 1;
        end
    end

    cipher_host i_dut (
        .clk    (clk),
        .rst    (rst),
        .req_i  (req),
        .rsp_o  (rsp),
        .busy_o (busy)
    );

    // Master key rotated left by r bytes, byte 0 XOR r
    function automatic block_t round_key_of(input block_t key, input int r);
        block_t rk;
        if (r == 0) begin
            rk = key;
        end else begin
            rk = (key << (8 * r)) | (key >> (`CIPHER_BLOCK_W - 8 * r));
        end
        rk[7:0] = rk[7:0] ^ 8'(r);
        return rk;
    endfunction

    function automatic block_t encrypt_round(input block_t s, input block_t rk);
        block_t sub;
        block_t sh;
        for (int i = 0; i < NBYTES; i++) begin
            sub[8*i +: 8] = s[8*i +: 8] + `CIPHER_SBOX_OFFSET;
        end
        sh = sub;
        sh[8*1 +: 8]  = sub[8*5 +: 8];
        sh[8*5 +: 8]  = sub[8*9 +: 8];
        sh[8*9 +: 8]  = sub[8*13 +: 8];
        sh[8*13 +: 8] = sub[8*1 +: 8];
        return sh ^ rk;
    endfunction

    function automatic block_t decrypt_round(input block_t s, input block_t rk);
        block_t x;
        block_t sh;
        x  = s ^ rk;
        sh = x;
        sh[8*5 +: 8]  = x[8*1 +: 8];
        sh[8*9 +: 8]  = x[8*5 +: 8];
        sh[8*13 +: 8] = x[8*9 +: 8];
        sh[8*1 +: 8]  = x[8*13 +: 8];
        for (int i = 0; i < NBYTES; i++) begin
            sh[8*i +: 8] = sh[8*i +: 8] - `CIPHER_SBOX_OFFSET;
        end
        return sh;
    endfunction

    function automatic block_t model_encrypt(input block_t text, input block_t key);
        block_t s;
        s = text;
        for (int r = 0; r < `CIPHER_ROUNDS; r++) begin
            s = encrypt_round(s, round_key_of(key, r));
        end
        return s;
    endfunction

    function automatic block_t model_decrypt(input block_t text, input block_t key);
        block_t s;
        s = text;
        for (int r = `CIPHER_ROUNDS - 1; r >= 0; r--) begin
            s = decrypt_round(s, round_key_of(key, r));
        end
        return s;
    endfunction

    task automatic rand_block(output block_t v);
        v = {$random(seed), $random(seed), $random(seed), $random(seed)};
    endtask

    task automatic check_rsp(input string name, input cipher_rsp_t exp,
                             input cipher_rsp_t act);
        if (act !== exp) begin
            $display("** Error %s: expected done=%0b data=%h, actual done=%0b data=%h",
                     name, exp.done, exp.data, act.done, act.data);
            err_count++;
        end
    endtask

    task automatic check_busy(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error %s busy: expected %0b, actual %0b", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("** Error %s: expected %0d, actual %0d", name, exp, act);
            err_count++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_count++;
        if (err_count == errs_before) begin
            $display("[PASS] %s", name);
        end else begin
            fail_count++;
            $display("[FAIL] %s with %0d errors", name, err_count - errs_before);
        end
    endtask

    // Call just after a falling edge
    task automatic drive_start(input cipher_op_e op, input block_t text, input block_t key);
        req.start = 1'b1;
        req.op    = op;
        req.text  = text;
        req.key   = key;
    endtask

    task automatic poll_done(input string name, output int cycles, output bit ok);
        cycles = 0;
        while (!rsp.done && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        ok = rsp.done;
        if (!ok) begin
            $display("%s: no done pulse within %0d cycles", name, DONE_TIMEOUT);
            err_count++;
        end
    endtask

    // Cycles counted from the edge that took the start
    task automatic wait_done(input string name, output int cycles, output bit ok);
        @(negedge clk);
        req.start = 1'b0;
        check_busy(name, 1'b1, busy);
        poll_done(name, cycles, ok);
    endtask

    task automatic run_op(input string name, input cipher_op_e op, input block_t text,
                          input block_t key, output block_t result);
        cipher_rsp_t exp;
        int          cycles;
        bit          ok;
        exp.done = 1'b1;
        exp.data = (op == OP_ENCRYPT) ? model_encrypt(text, key) : model_decrypt(text, key);
        @(negedge clk);  // One idle cycle before each request
        drive_start(op, text, key);
        wait_done(name, cycles, ok);
        if (ok) begin
            check_count({name, " latency"}, LATENCY, cycles);
            check_rsp(name, exp, rsp);
            check_busy(name, 1'b0, busy);
        end
        result = rsp.data;
    endtask

    task automatic reset_state_test();
        int errs;
        errs = err_count;
        check_rsp("reset_state", '0, rsp);
        check_busy("reset_state", 1'b0, busy);
        repeat (2) @(negedge clk);
        check_rsp("reset_state", '0, rsp);
        check_busy("reset_state", 1'b0, busy);
        check_count("reset_state done pulses", 0, done_count);
        finish_test("reset_state", errs);
    endtask

    task automatic encrypt_test();
        int     errs;
        block_t text;
        block_t key;
        block_t res;
        errs = err_count;
        run_op("encrypt_fixed", OP_ENCRYPT, 128'h00112233445566778899aabbccddeeff,
               128'h000102030405060708090a0b0c0d0e0f, res);
        run_op("encrypt_zero", OP_ENCRYPT, '0, '0, res);
        for (int i = 0; i < 4; i++) begin
            rand_block(text);
            rand_block(key);
            run_op("encrypt_random", OP_ENCRYPT, text, key, res);
        end
        finish_test("encrypt", errs);
    endtask

    task automatic decrypt_test();
        int     errs;
        block_t text;
        block_t key;
        block_t res;
        errs = err_count;
        run_op("decrypt_fixed", OP_DECRYPT, 128'h00112233445566778899aabbccddeeff,
               128'h000102030405060708090a0b0c0d0e0f, res);
        run_op("decrypt_ones", OP_DECRYPT, '1, '1, res);
        for (int i = 0; i < 4; i++) begin
            rand_block(text);
            rand_block(key);
            run_op("decrypt_random", OP_DECRYPT, text, key, res);
        end
        finish_test("decrypt", errs);
    endtask

    task automatic round_trip_test();
        int          errs;
        block_t      text;
        block_t      key;
        block_t      mid;
        block_t      back;
        cipher_rsp_t exp;
        errs = err_count;
        for (int i = 0; i < 3; i++) begin
            rand_block(text);
            rand_block(key);
            exp.done = 1'b1;
            exp.data = text;  // Must come back unchanged
            run_op("round_trip encrypt", OP_ENCRYPT, text, key, mid);
            run_op("round_trip decrypt", OP_DECRYPT, mid, key, back);
            check_rsp("round_trip enc then dec", exp, rsp);
            run_op("round_trip decrypt", OP_DECRYPT, text, key, mid);
            run_op("round_trip encrypt", OP_ENCRYPT, mid, key, back);
            check_rsp("round_trip dec then enc", exp, rsp);
        end
        finish_test("round_trip", errs);
    endtask

    task automatic busy_start_test();
        int          errs;
        int          cycles;
        int          dones;
        bit          ok;
        block_t      text;
        block_t      key;
        block_t      other;
        cipher_rsp_t exp;
        errs = err_count;
        rand_block(text);
        rand_block(key);
        rand_block(other);
        exp.done = 1'b1;
        exp.data = model_encrypt(text, key);
        @(negedge clk);
        dones = done_count;
        drive_start(OP_ENCRYPT, text, key);
        @(negedge clk);
        req.start = 1'b0;
        @(negedge clk);
        // Second strobe while busy, other op and key
        drive_start(OP_DECRYPT, other, ~key);
        @(negedge clk);
        req.start = 1'b0;
        check_busy("busy_start", 1'b1, busy);
        poll_done("busy_start", cycles, ok);
        if (ok) begin
            check_count("busy_start latency", LATENCY, cycles + 2);
            check_rsp("busy_start", exp, rsp);
        end
        repeat (LATENCY + 2) @(negedge clk);  // Room for a wrong second done
        check_count("busy_start done pulses", 1, done_count - dones);
        check_busy("busy_start idle", 1'b0, busy);
        finish_test("busy_start", errs);
    endtask

    task automatic back_to_back_test();
        int          errs;
        int          cycles;
        int          dones;
        bit          ok;
        block_t      t1;
        block_t      k1;
        block_t      t2;
        block_t      k2;
        cipher_rsp_t exp1;
        cipher_rsp_t exp2;
        errs = err_count;
        rand_block(t1);
        rand_block(k1);
        rand_block(t2);
        rand_block(k2);
        exp1.done = 1'b1;
        exp1.data = model_encrypt(t1, k1);
        exp2.done = 1'b1;
        exp2.data = model_decrypt(t2, k2);
        @(negedge clk);
        dones = done_count;
        drive_start(OP_ENCRYPT, t1, k1);
        wait_done("back_to_back first", cycles, ok);
        if (ok) begin
            check_rsp("back_to_back first", exp1, rsp);
        end
        drive_start(OP_DECRYPT, t2, k2);  // Same cycle as done
        wait_done("back_to_back second", cycles, ok);
        if (ok) begin
            check_count("back_to_back latency", LATENCY, cycles);
            check_rsp("back_to_back second", exp2, rsp);
        end
        @(negedge clk);
        check_count("back_to_back done pulses", 2, done_count - dones);
        finish_test("back_to_back", errs);
    endtask

    initial begin
        rst = 1'b1;
        req = '0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        reset_state_test();
        encrypt_test();
        decrypt_test();
        round_trip_test();
        busy_start_test();
        back_to_back_test();

        $display("Tests run %0d, tests failed %0d, errors %0d",
                 test_count, fail_count, err_count);
        if (err_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: sim/cipher_host_properties.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cipher host assertions
// Done strobe and busy timing checks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "cipher_defines.svh"

module cipher_host_properties (
    input logic                    clk,
    input logic                    rst,
    input cipher_pkg::cipher_req_t req_i,
    input cipher_pkg::cipher_rsp_t rsp_o,
    input logic                    busy_o
);

    // Done is registered at E+ROUNDS+1 and seen at the following sample
    localparam int DONE_DLY = `CIPHER_ROUNDS + 2;
    localparam int PRE_DLY  = DONE_DLY - 1;

    logic start_taken;

    assign start_taken = req_i.start && !busy_o;  // Idle engine only

    done_single_cycle: assert property (@(posedge clk) disable iff (rst)
        rsp_o.done |=> !rsp_o.done)
        else $error("done stayed high for more than one cycle");

    done_on_time: assert property (@(posedge clk) disable iff (rst)
        start_taken |-> ##DONE_DLY rsp_o.done)
        else $error("done missing at the expected cycle after start");

    // No early done
    done_not_early: assert property (@(posedge clk) disable iff (rst)
        start_taken |-> ##PRE_DLY !rsp_o.done)
        else $error("done arrived one cycle early");

    busy_falls_with_done: assert property (@(posedge clk) disable iff (rst)
        $fell(busy_o) |-> rsp_o.done)
        else $error("busy fell without a done pulse");

    done_not_busy: assert property (@(posedge clk) disable iff (rst)
        rsp_o.done |-> !busy_o)
        else $error("busy still high in the done cycle");

    reset_quiet: assert property (@(posedge clk)
        rst |-> (!rsp_o.done && !busy_o))
        else $error("done or busy high during reset");

endmodule

bind cipher_host cipher_host_properties i_props (
    .clk    (clk),
    .rst    (rst),
    .req_i  (req_i),
    .rsp_o  (rsp_o),
    .busy_o (busy_o)
);

// File: design/cipher_host.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cipher host top level
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "cipher_defines.svh"

module cipher_host (
    input  logic                    clk,
    input  logic                    rst,
    input  cipher_pkg::cipher_req_t req_i,
    output cipher_pkg::cipher_rsp_t rsp_o,
    output logic                    busy_o
);

    import cipher_pkg::*;

    logic                       key_load;
    logic [`CIPHER_ROUND_W-1:0] round_idx;
    cipher_op_e                 op;
    logic [`CIPHER_BLOCK_W-1:0] cur_state;
    logic [`CIPHER_BLOCK_W-1:0] next_state;
    logic [`CIPHER_BLOCK_W-1:0] round_key;

    cipher_engine i_engine (
        .clk          (clk),
        .rst          (rst),
        .req_i        (req_i),
        .round_key_i  (round_key),
        .next_state_i (next_state),
        .key_load_o   (key_load),
        .round_idx_o  (round_idx),
        .op_o         (op),
        .cur_state_o  (cur_state),
        .rsp_o        (rsp_o),
        .busy_o       (busy_o)
    );

    cipher_key_schedule i_key_schedule (
        .clk          (clk),
        .rst          (rst),
        .key_load_i   (key_load),
        .key_i        (req_i.key),
        .round_idx_i  (round_idx),
        .round_key_o  (round_key)
    );

    cipher_round_unit i_round_unit (
        .op_i         (op),
        .state_i      (cur_state),
        .round_key_i  (round_key),
        .state_o      (next_state)
    );

endmodule

// File: design/cipher_engine.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cipher engine FSM
// Sequences rounds, registers the result
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "cipher_defines.svh"

module cipher_engine (
    input  logic                         clk,
    input  logic                         rst,
    input  cipher_pkg::cipher_req_t      req_i,
    input  logic [`CIPHER_BLOCK_W-1:0]   round_key_i,
    input  logic [`CIPHER_BLOCK_W-1:0]   next_state_i,
    output logic                         key_load_o,
    output logic [`CIPHER_ROUND_W-1:0]   round_idx_o,
    output cipher_pkg::cipher_op_e       op_o,
    output logic [`CIPHER_BLOCK_W-1:0]   cur_state_o,
    output cipher_pkg::cipher_rsp_t      rsp_o,
    output logic                         busy_o
);

    import cipher_pkg::*;

    localparam logic [`CIPHER_ROUND_W-1:0] LAST_ROUND = `CIPHER_ROUNDS - 1;

    engine_state_e               state_q;
    cipher_op_e                  op_q;
    logic [`CIPHER_ROUND_W-1:0]  round_q;
    logic [`CIPHER_BLOCK_W-1:0]  data_q;     // Cipher state
    cipher_rsp_t                 rsp_q;

    logic start_ok;
    logic last_round;

    // Only an idle engine takes a start
    assign start_ok = (state_q == ST_IDLE) && req_i.start;

    // Encrypt ends at the top index, decrypt at zero
    assign last_round = (op_q == OP_ENCRYPT) ? (round_q == LAST_ROUND)
                                             : (round_q == '0);

    // FSM, counter and response
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= ST_IDLE;
            op_q    <= OP_ENCRYPT;
            round_q <= '0;
            rsp_q   <= '0;
        end else begin
            rsp_q.done <= 1'b0;  // Strobe by default

            case (state_q)
                ST_IDLE: begin
                    if (start_ok) begin
                        op_q    <= req_i.op;
                        round_q <= (req_i.op == OP_DECRYPT) ? LAST_ROUND : '0;
                        state_q <= ST_ROUND;
                    end
                end

                ST_ROUND: begin
                    if (last_round) begin
                        state_q <= ST_OUTPUT;
                    end else if (op_q == OP_ENCRYPT) begin
                        round_q <= round_q + 1'b1;
                    end else begin
                        round_q <= round_q - 1'b1;
                    end
                end

                ST_OUTPUT: begin
                    rsp_q.done <= 1'b1;
                    rsp_q.data <= data_q;
                    state_q    <= ST_IDLE;
                end

                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Text load on start, one round result per ST_ROUND cycle
    always_ff @(posedge clk) begin
        if (start_ok) begin
            data_q <= req_i.text;
        end else if (state_q == ST_ROUND) begin
            data_q <= next_state_i;
        end
    end

    // Round key comes back here for the round unit's view
    assign key_load_o  = start_ok;
    assign round_idx_o = round_q;
    assign op_o        = op_q;
    assign cur_state_o = data_q;
    assign rsp_o       = rsp_q;
    assign busy_o      = (state_q != ST_IDLE);

endmodule

// File: design/cipher_round_unit.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cipher round datapath
// One forward or inverse round, combinational
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "cipher_defines.svh"

module cipher_round_unit (
    input  cipher_pkg::cipher_op_e     op_i,
    input  logic [`CIPHER_BLOCK_W-1:0] state_i,
    input  logic [`CIPHER_BLOCK_W-1:0] round_key_i,
    output logic [`CIPHER_BLOCK_W-1:0] state_o
);

    import cipher_pkg::*;

    localparam int NBYTES = `CIPHER_BLOCK_W / 8;

    // Byte i sits at bits 8i+7:8i
    logic [NBYTES-1:0][7:0] in_b;
    logic [NBYTES-1:0][7:0] key_b;

    // Forward path
    logic [NBYTES-1:0][7:0] fwd_sub;
    logic [NBYTES-1:0][7:0] fwd_shift;
    logic [NBYTES-1:0][7:0] fwd_b;

    // Inverse path
    logic [NBYTES-1:0][7:0] inv_x;
    logic [NBYTES-1:0][7:0] inv_shift;
    logic [NBYTES-1:0][7:0] inv_b;

    assign in_b  = state_i;
    assign key_b = round_key_i;

    // Encrypt round: substitute, shift, add key
    always_comb begin
        for (int i = 0; i < NBYTES; i++) begin
            fwd_sub[i] = in_b[i] + `CIPHER_SBOX_OFFSET;
        end

        // Partial row shift on bytes 1, 5, 9, 13
        fwd_shift     = fwd_sub;
        fwd_shift[1]  = fwd_sub[5];
        fwd_shift[5]  = fwd_sub[9];
        fwd_shift[9]  = fwd_sub[13];
        fwd_shift[13] = fwd_sub[1];

        fwd_b = fwd_shift ^ key_b;
    end

    // Decrypt round, steps reversed
    always_comb begin
        inv_x = in_b ^ key_b;

        // Undo the rotation
        inv_shift     = inv_x;
        inv_shift[5]  = inv_x[1];
        inv_shift[9]  = inv_x[5];
        inv_shift[13] = inv_x[9];
        inv_shift[1]  = inv_x[13];

        for (int i = 0; i < NBYTES; i++) begin
            inv_b[i] = inv_shift[i] - `CIPHER_SBOX_OFFSET;
        end
    end

    assign state_o = (op_i == OP_ENCRYPT) ? fwd_b : inv_b;

endmodule

// File: design/cipher_key_schedule.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cipher key schedule
// Holds the master key, derives round keys
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "cipher_defines.svh"

module cipher_key_schedule (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       key_load_i,
    input  logic [`CIPHER_BLOCK_W-1:0] key_i,
    input  logic [`CIPHER_ROUND_W-1:0] round_idx_i,
    output logic [`CIPHER_BLOCK_W-1:0] round_key_o
);

    logic [`CIPHER_BLOCK_W-1:0]   key_q;
    logic [2*`CIPHER_BLOCK_W-1:0] key_dbl;
    logic [`CIPHER_BLOCK_W-1:0]   key_rot;
    logic [7:0]                   idx_byte;

    // Master key, captured with the accepted start
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            key_q <= '0;
        end else if (key_load_i) begin
            key_q <= key_i;
        end
    end

    // Rotate left by 8*r bits using the doubled key
    always_comb begin
        key_dbl = {key_q, key_q} << {round_idx_i, 3'b000};
        key_rot = key_dbl[2*`CIPHER_BLOCK_W-1:`CIPHER_BLOCK_W];
    end

    assign idx_byte = {{(8-`CIPHER_ROUND_W){1'b0}}, round_idx_i};

    // Byte 0 takes the round index
    assign round_key_o = {key_rot[`CIPHER_BLOCK_W-1:8], key_rot[7:0] ^ idx_byte};

endmodule

// File: design/cipher_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cipher host types
// Opcodes, engine states, request/response
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "cipher_defines.svh"

package cipher_pkg;

    // Operation select
    typedef enum logic {
        OP_ENCRYPT = 1'b0,
        OP_DECRYPT = 1'b1
    } cipher_op_e;

    // Engine FSM states
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_ROUND  = 2'd1,  // One round per clock
        ST_OUTPUT = 2'd2   // Result register and done pulse
    } engine_state_e;

    // Request from the outside world, 258 bits
    typedef struct packed {
        logic                       start;  // One-cycle strobe
        cipher_op_e                 op;
        logic [`CIPHER_BLOCK_W-1:0] text;
        logic [`CIPHER_BLOCK_W-1:0] key;
    } cipher_req_t;

    // Response, 129 bits
    typedef struct packed {
        logic                       done;   // One-cycle strobe
        logic [`CIPHER_BLOCK_W-1:0] data;   // Held until next done
    } cipher_rsp_t;

endpackage

// File: design/cipher_defines.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cipher host constants
// Round count, S-box offset and widths
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef CIPHER_DEFINES_SVH
`define CIPHER_DEFINES_SVH

// Rounds per operation, 1 to 15 fit the round index
`define CIPHER_ROUNDS 10

// Added by substitution, subtracted by the inverse
`define CIPHER_SBOX_OFFSET 8'hEF

// Round index width
`define CIPHER_ROUND_W 4

// Text and key width, 16 bytes
`define CIPHER_BLOCK_W 128

`endif
